//--- logic/csr_pkg.sv
// Machine-mode CSR definitions shared by the CSR file, the top level and the testbench.
// Only M and U privilege are implemented; S exists in the encoding but is never entered.
// Causes are XLEN wide with bit XLEN-1 set for interrupts, as the privileged spec encodes them.
package csr_pkg;

    localparam int unsigned CSR_ADDR_SIZE = 12;
    localparam int unsigned XLEN          = 64;

    typedef enum logic [1:0] {
        CSR_CMD_NONE  = 2'd0,                      // plain read, no side effect
        CSR_CMD_WRITE = 2'd1,
        CSR_CMD_SET   = 2'd2,
        CSR_CMD_CLEAR = 2'd3
    } csr_cmd_t;

    typedef enum logic [1:0] {
        PRIV_LVL_U = 2'd0,
        PRIV_LVL_S = 2'd1,
        PRIV_LVL_M = 2'd3
    } priv_lvl_t;

    // ------------------------------
    // csr addresses
    localparam logic [CSR_ADDR_SIZE-1:0] CSR_SATP     = 12'h180;
    localparam logic [CSR_ADDR_SIZE-1:0] CSR_MSTATUS  = 12'h300;
    localparam logic [CSR_ADDR_SIZE-1:0] CSR_MIE      = 12'h304;
    localparam logic [CSR_ADDR_SIZE-1:0] CSR_MTVEC    = 12'h305;
    localparam logic [CSR_ADDR_SIZE-1:0] CSR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_SIZE-1:0] CSR_MCAUSE   = 12'h342;
    localparam logic [CSR_ADDR_SIZE-1:0] CSR_MTVAL    = 12'h343;
    localparam logic [CSR_ADDR_SIZE-1:0] CSR_MCYCLE   = 12'hB00;
    localparam logic [CSR_ADDR_SIZE-1:0] CSR_MINSTRET = 12'hB02;
    localparam logic [CSR_ADDR_SIZE-1:0] CSR_CYCLE    = 12'hC00; // read-only shadow of mcycle
    localparam logic [CSR_ADDR_SIZE-1:0] CSR_INSTRET  = 12'hC02; // read-only shadow of minstret

    // ------------------------------
    // causes and interrupt bits
    localparam logic [XLEN-1:0] CAUSE_ILLEGAL_INSN = 64'd2;
    localparam logic [XLEN-1:0] CAUSE_M_TIMER_IRQ  = {1'b1, 63'd7};
    localparam logic [XLEN-1:0] CAUSE_M_EXT_IRQ    = {1'b1, 63'd11};
    localparam int unsigned     IRQ_MTI            = 7;      // mie.MTIE position
    localparam int unsigned     IRQ_MEI            = 11;     // mie.MEIE position

    localparam logic [3:0] SATP_MODE_BARE = 4'd0;
    localparam logic [3:0] SATP_MODE_SV39 = 4'd8;

    typedef struct packed {
        logic [50:0] rsvd_hi;                      // 63:13, reads zero
        priv_lvl_t   mpp;                          // 12:11
        logic [2:0]  rsvd_mid;
        logic        mpie;                         // bit 7
        logic [2:0]  rsvd_lo;
        logic        mie;                          // bit 3
        logic [2:0]  rsvd_0;
    } mstatus_t;

    typedef struct packed {
        logic [3:0]  mode;
        logic [15:0] asid;
        logic [43:0] ppn;
    } satp_t;

    // one data word, seen either as mstatus or as satp
    typedef union packed {
        mstatus_t mstatus;
        satp_t    satp;
    } csr_word_u;

endpackage

//--- logic/pmu_pkg.sv
// Performance monitor definitions.
// Event indices are bit positions in the event vector of the counter bank, so a bank
// with fewer counters than events simply drops the high events.
// Counters sit at consecutive addresses from HPM_BASE_ADDR (mhpmcounter3 upward).
package pmu_pkg;

    // ------------------------------
    // event vector bits
    localparam int unsigned ev_branch_miss = 0;    // mispredicted branch resolved
    localparam int unsigned ev_icache_miss = 1;
    localparam int unsigned ev_dtlb_miss   = 2;
    localparam int unsigned ev_stall       = 3;    // any pipeline stall cycle

    // first hpm counter, the window grows upward by one address per counter
    localparam logic [11:0] HPM_BASE_ADDR = 12'hB03;

endpackage

//--- logic/hpm_counters.sv
// Bank of hardware performance counters at consecutive CSR addresses from HPM_BASE_ADDR.
// Counters are COUNTER_WIDTH bits (up to 64), wrap silently and read back zero-extended.
// A write in the same cycle as an event wins, the event is lost.
// Reads outside the window return zero.
`timescale 1ns/1ns

module hpm_counters #(
    parameter int unsigned NUM_COUNTERS  = 4,
    parameter int unsigned COUNTER_WIDTH = 40
) (
    input  logic                              clk_i,
    input  logic                              rstn_i,
    input  logic [csr_pkg::CSR_ADDR_SIZE-1:0] addr_i,
    input  logic                              we_i,
    input  logic [csr_pkg::XLEN-1:0]          data_i,
    input  logic [NUM_COUNTERS-1:0]           event_i,
    output logic [csr_pkg::XLEN-1:0]          data_o
);
    import csr_pkg::*;
    import pmu_pkg::*;

    logic [COUNTER_WIDTH-1:0] cnt_q [NUM_COUNTERS];
    logic [NUM_COUNTERS-1:0]  hit;                 // one-hot address match

    // ------------------------------
    // address match and read
    always_comb begin
        data_o = '0;
        for (int i = 0; i < NUM_COUNTERS; i++) begin
            hit[i] = (addr_i == HPM_BASE_ADDR + CSR_ADDR_SIZE'(i));
            if (hit[i]) data_o = XLEN'(cnt_q[i]);  // zero-extend to the bus
        end
    end

    // ------------------------------
    // counters
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < NUM_COUNTERS; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_COUNTERS; i++) begin
                if (we_i && hit[i]) begin
                    cnt_q[i] <= data_i[COUNTER_WIDTH-1:0]; // upper bits dropped
                end else if (event_i[i]) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;           // wraps at COUNTER_WIDTH
                end
            end
        end
    end

    // the CSR file only forwards writes that fall inside this bank
    a_we_in_window: assert property (@(posedge clk_i) disable iff (!rstn_i)
        we_i |-> (|hit));

endmodule

//--- logic/csr_file.sv
// Machine-mode CSR file for an in-order core, M and U privilege only.
// A command other than none to an unknown or read-only address is illegal; a plain read
// (command none) never traps. mtvec and mepc keep all 64 bits, mie keeps MTIE and MEIE.
// Trap entry and return take priority over a CSR command in the same cycle.
// satp writes with an unsupported mode are dropped whole.
`timescale 1ns/1ns

module csr_file #(
    parameter int unsigned NUM_COUNTERS = 4
) (
    input  logic                              clk_i,
    input  logic                              rstn_i,
    input  logic [csr_pkg::CSR_ADDR_SIZE-1:0] rw_addr_i,
    input  csr_pkg::csr_cmd_t                 rw_cmd_i,
    input  logic [csr_pkg::XLEN-1:0]          w_data_i,
    input  logic                              ex_i,
    input  logic [csr_pkg::XLEN-1:0]          ex_cause_i,
    input  logic [csr_pkg::XLEN-1:0]          ex_pc_i,
    input  logic [csr_pkg::XLEN-1:0]          ex_tval_i,
    input  logic                              eret_i,
    input  logic                              retire_i,
    input  logic                              time_irq_i,
    input  logic                              irq_i,
    input  logic [csr_pkg::XLEN-1:0]          perf_data_i,
    output logic [csr_pkg::XLEN-1:0]          r_data_o,
    output logic                              csr_xcpt_o,
    output logic [csr_pkg::XLEN-1:0]          csr_xcpt_cause_o,
    output logic                              interrupt_o,
    output logic [csr_pkg::XLEN-1:0]          interrupt_cause_o,
    output logic [csr_pkg::XLEN-1:0]          evec_o,
    output csr_pkg::priv_lvl_t                priv_lvl_o,
    output logic                              en_translation_o,
    output logic [43:0]                       satp_ppn_o,
    output logic [csr_pkg::CSR_ADDR_SIZE-1:0] perf_addr_o,
    output logic                              perf_we_o,
    output logic [csr_pkg::XLEN-1:0]          perf_data_o
);
    import csr_pkg::*;
    import pmu_pkg::*;

    localparam logic [XLEN-1:0] MIE_MASK = (64'd1 << IRQ_MTI) | (64'd1 << IRQ_MEI);

    csr_word_u        mstatus_q, satp_q, wr_val;
    logic [XLEN-1:0]  mie_q, mtvec_q, mepc_q, mcause_q, mtval_q, mcycle_q, minstret_q;
    priv_lvl_t        priv_q;
    logic [XLEN-1:0]  rdata;
    logic             in_hpm, addr_known, addr_ro, illegal, wr_en;
    logic             tmr_pend, ext_pend;

    // ------------------------------
    // address decode and read mux
    assign in_hpm = (rw_addr_i >= HPM_BASE_ADDR) &&
                    (rw_addr_i < HPM_BASE_ADDR + CSR_ADDR_SIZE'(NUM_COUNTERS));

    always_comb begin
        rdata      = '0;
        addr_known = 1'b1;
        addr_ro    = 1'b0;
        if (in_hpm) begin
            rdata = perf_data_i;                   // counter bank answers in the same cycle
        end else begin
            case (rw_addr_i)
                CSR_MSTATUS:  rdata = mstatus_q;
                CSR_MIE:      rdata = mie_q;
                CSR_MTVEC:    rdata = mtvec_q;
                CSR_MEPC:     rdata = mepc_q;
                CSR_MCAUSE:   rdata = mcause_q;
                CSR_MTVAL:    rdata = mtval_q;
                CSR_SATP:     rdata = satp_q;
                CSR_MCYCLE:   rdata = mcycle_q;
                CSR_MINSTRET: rdata = minstret_q;
                CSR_CYCLE: begin
                    rdata   = mcycle_q;
                    addr_ro = 1'b1;
                end
                CSR_INSTRET: begin
                    rdata   = minstret_q;
                    addr_ro = 1'b1;
                end
                default: addr_known = 1'b0;
            endcase
        end
    end

    // merge the command into the current value
    always_comb begin
        case (rw_cmd_i)
            CSR_CMD_WRITE: wr_val = w_data_i;
            CSR_CMD_SET:   wr_val = rdata | w_data_i;
            CSR_CMD_CLEAR: wr_val = rdata & ~w_data_i;
            default:       wr_val = rdata;
        endcase
    end

    assign illegal = (rw_cmd_i != CSR_CMD_NONE) && (!addr_known || addr_ro);
    assign wr_en   = (rw_cmd_i != CSR_CMD_NONE) && !illegal;

    assign r_data_o         = rdata;
    assign csr_xcpt_o       = illegal;
    assign csr_xcpt_cause_o = illegal ? CAUSE_ILLEGAL_INSN : '0;

    // hpm accesses go straight through, the bank decodes the index
    assign perf_addr_o = rw_addr_i;
    assign perf_data_o = wr_val;
    assign perf_we_o   = wr_en && in_hpm;

    // ------------------------------
    // registers
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            mstatus_q  <= '0;
            satp_q     <= '0;
            mie_q      <= '0;
            mtvec_q    <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
            mcycle_q   <= '0;
            minstret_q <= '0;
            priv_q     <= PRIV_LVL_M;
        end else begin
            mcycle_q <= mcycle_q + 1'b1;
            if (retire_i) minstret_q <= minstret_q + 1'b1;
            if (wr_en) begin                       // later writes here beat the increments
                case (rw_addr_i)
                    CSR_MSTATUS: begin
                        mstatus_q.mstatus.mie  <= wr_val.mstatus.mie;
                        mstatus_q.mstatus.mpie <= wr_val.mstatus.mpie;
                        // no S mode, anything but M lands in U
                        mstatus_q.mstatus.mpp  <= (wr_val.mstatus.mpp == PRIV_LVL_M) ?
                                                  PRIV_LVL_M : PRIV_LVL_U;
                    end
                    CSR_MIE:      mie_q      <= wr_val & MIE_MASK;
                    CSR_MTVEC:    mtvec_q    <= wr_val;
                    CSR_MEPC:     mepc_q     <= wr_val;
                    CSR_MCAUSE:   mcause_q   <= wr_val;
                    CSR_MTVAL:    mtval_q    <= wr_val;
                    CSR_MCYCLE:   mcycle_q   <= wr_val;
                    CSR_MINSTRET: minstret_q <= wr_val;
                    CSR_SATP: begin
                        if (wr_val.satp.mode == SATP_MODE_BARE ||
                            wr_val.satp.mode == SATP_MODE_SV39) begin
                            satp_q <= wr_val;
                        end
                    end
                    default: ;                     // hpm window, handled by the bank
                endcase
            end
            // trap entry / return, override any command above
            if (ex_i) begin
                mepc_q                 <= ex_pc_i;
                mcause_q               <= ex_cause_i;
                mtval_q                <= ex_tval_i;
                mstatus_q.mstatus.mpie <= mstatus_q.mstatus.mie;
                mstatus_q.mstatus.mie  <= 1'b0;
                mstatus_q.mstatus.mpp  <= priv_q;
                priv_q                 <= PRIV_LVL_M;
            end else if (eret_i) begin
                priv_q                 <= mstatus_q.mstatus.mpp;
                mstatus_q.mstatus.mie  <= mstatus_q.mstatus.mpie;
                mstatus_q.mstatus.mpie <= 1'b1;    // as mret defines it
                mstatus_q.mstatus.mpp  <= PRIV_LVL_U;
            end
        end
    end

    // ------------------------------
    // interrupts, translation, trap vector
    assign tmr_pend          = time_irq_i && mie_q[IRQ_MTI];
    assign ext_pend          = irq_i && mie_q[IRQ_MEI];
    assign interrupt_o       = mstatus_q.mstatus.mie && (tmr_pend || ext_pend);
    assign interrupt_cause_o = tmr_pend ? CAUSE_M_TIMER_IRQ :  // timer wins
                               ext_pend ? CAUSE_M_EXT_IRQ   : '0;

    assign evec_o           = mtvec_q;
    assign priv_lvl_o       = priv_q;
    assign satp_ppn_o       = satp_q.satp.ppn;
    assign en_translation_o = (satp_q.satp.mode == SATP_MODE_SV39) && (priv_q != PRIV_LVL_M);

    // the core never retires an mret on the same cycle as it traps
    a_ex_eret_excl: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(ex_i && eret_i));

    // an illegal command leaves every CSR and the counter bank untouched
    a_xcpt_no_write: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (csr_xcpt_o && !ex_i) |-> !perf_we_o ##1
        ($stable(mtvec_q) && $stable(mie_q) && $stable(satp_q) &&
         $stable(mepc_q) && $stable(mcause_q) && $stable(mtval_q)));

endmodule

//--- logic/csr_top.sv
// CSR subsystem top: machine CSR file plus the hpm counter bank.
// Core-side signals are plain strobes and levels, every command completes in one cycle.
// event_i carries one bit per counter, ordered as the pmu_pkg event indices.
`timescale 1ns/1ns

module csr_top #(
    parameter int unsigned NUM_COUNTERS  = 4,
    parameter int unsigned COUNTER_WIDTH = 40  // up to 64
) (
    input  logic                              clk_i,
    input  logic                              rstn_i,
    // csr command from the core
    input  logic [csr_pkg::CSR_ADDR_SIZE-1:0] rw_addr_i,
    input  csr_pkg::csr_cmd_t                 rw_cmd_i,
    input  logic [csr_pkg::XLEN-1:0]          w_data_i,
    output logic [csr_pkg::XLEN-1:0]          r_data_o,
    // traps
    input  logic                              ex_i,
    input  logic [csr_pkg::XLEN-1:0]          ex_cause_i,
    input  logic [csr_pkg::XLEN-1:0]          ex_pc_i,
    input  logic [csr_pkg::XLEN-1:0]          ex_tval_i,
    input  logic                              eret_i,
    input  logic                              retire_i,
    output logic                              csr_xcpt_o,
    output logic [csr_pkg::XLEN-1:0]          csr_xcpt_cause_o,
    output logic [csr_pkg::XLEN-1:0]          evec_o,
    // interrupts
    input  logic                              time_irq_i,
    input  logic                              irq_i,
    output logic                              interrupt_o,
    output logic [csr_pkg::XLEN-1:0]          interrupt_cause_o,
    // status towards fetch and the mmu
    output csr_pkg::priv_lvl_t                priv_lvl_o,
    output logic                              en_translation_o,
    output logic [43:0]                       satp_ppn_o,
    // perf events
    input  logic [NUM_COUNTERS-1:0]           event_i
);
    import csr_pkg::*;

    // csr file <-> counter bank
    logic [CSR_ADDR_SIZE-1:0] perf_addr;
    logic                     perf_we;
    logic [XLEN-1:0]          perf_wdata, perf_rdata;

    csr_file #(
        .NUM_COUNTERS (NUM_COUNTERS)
    ) csr_file_inst (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .rw_addr_i         (rw_addr_i),
        .rw_cmd_i          (rw_cmd_i),
        .w_data_i          (w_data_i),
        .ex_i              (ex_i),
        .ex_cause_i        (ex_cause_i),
        .ex_pc_i           (ex_pc_i),
        .ex_tval_i         (ex_tval_i),
        .eret_i            (eret_i),
        .retire_i          (retire_i),
        .time_irq_i        (time_irq_i),
        .irq_i             (irq_i),
        .perf_data_i       (perf_rdata),
        .r_data_o          (r_data_o),
        .csr_xcpt_o        (csr_xcpt_o),
        .csr_xcpt_cause_o  (csr_xcpt_cause_o),
        .interrupt_o       (interrupt_o),
        .interrupt_cause_o (interrupt_cause_o),
        .evec_o            (evec_o),
        .priv_lvl_o        (priv_lvl_o),
        .en_translation_o  (en_translation_o),
        .satp_ppn_o        (satp_ppn_o),
        .perf_addr_o       (perf_addr),
        .perf_we_o         (perf_we),
        .perf_data_o       (perf_wdata)
    );

    hpm_counters #(
        .NUM_COUNTERS  (NUM_COUNTERS),
        .COUNTER_WIDTH (COUNTER_WIDTH)
    ) hpm_counters_inst (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .addr_i  (perf_addr),
        .we_i    (perf_we),
        .data_i  (perf_wdata),
        .event_i (event_i),
        .data_o  (perf_rdata)
    );

endmodule

//--- test/tb_csr_tasks.svh
// Compare, CSR access and directed test tasks, included inside tb_csr_top.
// Every access task starts on a rising edge and returns once the command has been taken,
// so a command written by one task is visible to the next one.
`ifndef TB_CSR_TASKS_SVH
`define TB_CSR_TASKS_SVH

// ------------------------------
// helpers
task automatic compare(input string name, input logic [XLEN-1:0] got,
                       input logic [XLEN-1:0] exp);
    chk_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
endtask

function automatic logic [XLEN-1:0] random_word();
    return {$random(seed), $random(seed)};
endfunction

// one command, held for a single cycle
task automatic issue_cmd(input logic [CSR_ADDR_SIZE-1:0] addr, input csr_cmd_t cmd,
                         input logic [XLEN-1:0] data);
    @(posedge clk_i);
    rw_addr_i <= addr;
    rw_cmd_i  <= cmd;
    w_data_i  <= data;
    @(negedge clk_i);
    last_xcpt  = csr_xcpt_o;                      // exception is combinational
    last_cause = csr_xcpt_cause_o;
    @(posedge clk_i);                             // register updates on this edge
    rw_cmd_i <= CSR_CMD_NONE;
endtask

task automatic read_csr(input logic [CSR_ADDR_SIZE-1:0] addr, output logic [XLEN-1:0] data);
    @(posedge clk_i);
    rw_addr_i <= addr;
    rw_cmd_i  <= CSR_CMD_NONE;
    @(negedge clk_i);
    data = r_data_o;
endtask

task automatic expect_read(input logic [CSR_ADDR_SIZE-1:0] addr, input logic [XLEN-1:0] exp);
    logic [XLEN-1:0] val;
    read_csr(addr, val);
    compare($sformatf("r_data_o @0x%h", addr), val, exp);
endtask

task automatic raise_trap(input logic [XLEN-1:0] cause, input logic [XLEN-1:0] pc,
                          input logic [XLEN-1:0] tval);
    @(posedge clk_i);
    ex_i       <= 1'b1;
    ex_cause_i <= cause;
    ex_pc_i    <= pc;
    ex_tval_i  <= tval;
    @(posedge clk_i);
    ex_i <= 1'b0;
    @(negedge clk_i);
endtask

task automatic trap_return();
    @(posedge clk_i);
    eret_i <= 1'b1;
    @(posedge clk_i);
    eret_i <= 1'b0;
    @(negedge clk_i);
endtask

task automatic drive_irq(input logic tmr, input logic ext);
    @(posedge clk_i);
    time_irq_i <= tmr;
    irq_i      <= ext;
    @(negedge clk_i);
endtask

// ------------------------------
// directed tests
task automatic csr_command_rules();
    logic [CSR_ADDR_SIZE-1:0] addr;
    logic [XLEN-1:0]          exp;
    logic [XLEN-1:0]          mask;
    for (int k = 0; k < 2; k++) begin
        addr = (k == 0) ? CSR_MTVEC : CSR_MEPC;
        exp  = random_word();
        issue_cmd(addr, CSR_CMD_WRITE, exp);
        compare("csr_xcpt_o on legal write", last_xcpt, 1'b0);
        expect_read(addr, exp);
        mask = random_word();
        exp  = exp | mask;                        // set ors the bits in
        issue_cmd(addr, CSR_CMD_SET, mask);
        expect_read(addr, exp);
        mask = random_word();
        exp  = exp & ~mask;                       // clear masks them out
        issue_cmd(addr, CSR_CMD_CLEAR, mask);
        expect_read(addr, exp);
        if (addr == CSR_MTVEC) compare("evec_o", evec_o, exp);
    end
endtask

task automatic illegal_access();
    logic [XLEN-1:0] keep;
    logic [XLEN-1:0] cnt;
    keep = random_word();
    issue_cmd(CSR_MTVEC, CSR_CMD_WRITE, keep);
    issue_cmd(12'h7C0, CSR_CMD_WRITE, ~keep);    // nothing lives at 0x7c0
    compare("csr_xcpt_o unknown addr", last_xcpt, 1'b1);
    compare("csr_xcpt_cause_o unknown addr", last_cause, 64'd2);
    expect_read(CSR_MTVEC, keep);
    // minstret stays put while retire_i is low
    cnt = random_word();
    issue_cmd(CSR_MINSTRET, CSR_CMD_WRITE, cnt);
    issue_cmd(CSR_INSTRET, CSR_CMD_WRITE, ~cnt);  // read-only shadow
    compare("csr_xcpt_o read-only write", last_xcpt, 1'b1);
    compare("csr_xcpt_cause_o read-only write", last_cause, 64'd2);
    expect_read(CSR_INSTRET, cnt);
endtask

task automatic trap_entry_return();
    csr_word_u       st;
    logic [XLEN-1:0] val;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] tval;
    st              = '0;
    st.mstatus.mpp  = PRIV_LVL_U;
    st.mstatus.mpie = 1'b1;
    issue_cmd(CSR_MSTATUS, CSR_CMD_WRITE, st);
    trap_return();                                // drop to user
    compare("priv_lvl_o after eret", priv_lvl_o, PRIV_LVL_U);
    read_csr(CSR_MSTATUS, val);
    st = val;
    compare("mstatus.MIE after eret", st.mstatus.mie, 1'b1);
    compare("mstatus.MPP after eret", st.mstatus.mpp, PRIV_LVL_U);
    // MPP and MPIE start opposite to what the trap leaves in them
    st              = '0;
    st.mstatus.mie  = 1'b1;
    st.mstatus.mpp  = PRIV_LVL_M;
    issue_cmd(CSR_MSTATUS, CSR_CMD_WRITE, st);
    pc   = random_word();
    tval = random_word();
    raise_trap(64'd13, pc, tval);                 // load page fault
    compare("priv_lvl_o after trap", priv_lvl_o, PRIV_LVL_M);
    expect_read(CSR_MEPC, pc);
    expect_read(CSR_MCAUSE, 64'd13);
    expect_read(CSR_MTVAL, tval);
    read_csr(CSR_MSTATUS, val);
    st = val;
    compare("mstatus.MPP after trap", st.mstatus.mpp, PRIV_LVL_U);
    compare("mstatus.MIE after trap", st.mstatus.mie, 1'b0);
    compare("mstatus.MPIE after trap", st.mstatus.mpie, 1'b1);
    trap_return();
    compare("priv_lvl_o after second eret", priv_lvl_o, PRIV_LVL_U);
    read_csr(CSR_MSTATUS, val);
    st = val;
    compare("mstatus.MIE after second eret", st.mstatus.mie, 1'b1);
endtask

task automatic irq_masking();
    csr_word_u st;
    st             = '0;
    st.mstatus.mie = 1'b1;
    st.mstatus.mpp = PRIV_LVL_M;
    issue_cmd(CSR_MSTATUS, CSR_CMD_WRITE, st);
    issue_cmd(CSR_MIE, CSR_CMD_WRITE, '0);
    drive_irq(1'b1, 1'b1);
    compare("interrupt_o with mie zero", interrupt_o, 1'b0);
    issue_cmd(CSR_MIE, CSR_CMD_WRITE, 64'h80);    // MTIE only
    drive_irq(1'b0, 1'b1);
    compare("interrupt_o ext masked", interrupt_o, 1'b0);
    issue_cmd(CSR_MIE, CSR_CMD_SET, 64'h800);     // add MEIE
    drive_irq(1'b1, 1'b1);
    compare("interrupt_o both pending", interrupt_o, 1'b1);
    compare("interrupt_cause_o timer first", interrupt_cause_o, {1'b1, 63'd7});
    drive_irq(1'b0, 1'b1);
    compare("interrupt_o ext only", interrupt_o, 1'b1);
    compare("interrupt_cause_o ext", interrupt_cause_o, {1'b1, 63'd11});
    issue_cmd(CSR_MSTATUS, CSR_CMD_CLEAR, 64'h8); // global MIE off
    drive_irq(1'b1, 1'b1);
    compare("interrupt_o with MIE clear", interrupt_o, 1'b0);
    drive_irq(1'b0, 1'b0);
endtask

task automatic counter_events();
    logic [XLEN-1:0]         start [NUM_COUNTERS];
    logic [NUM_COUNTERS-1:0] sel;
    logic [31:0]             rnd;
    int                      n;
    int                      retired;
    n   = 9;
    sel = '0;
    sel[ev_icache_miss] = 1'b1;
    sel[ev_stall]       = 1'b1;
    for (int i = 0; i < NUM_COUNTERS; i++) begin
        rnd      = $random(seed);
        start[i] = {32'd0, rnd};                  // no wrap within n events
        issue_cmd(HPM_BASE_ADDR + 12'(i), CSR_CMD_WRITE, start[i]);
    end
    @(posedge clk_i);
    event_i <= sel;
    repeat (n) @(posedge clk_i);                  // n edges see the events
    event_i <= '0;
    for (int i = 0; i < NUM_COUNTERS; i++) begin
        expect_read(HPM_BASE_ADDR + 12'(i), sel[i] ? start[i] + 64'(n) : start[i]);
    end
    // wrap at COUNTER_WIDTH
    issue_cmd(HPM_BASE_ADDR + 12'(ev_stall), CSR_CMD_WRITE, '1);
    expect_read(HPM_BASE_ADDR + 12'(ev_stall), (64'd1 << COUNTER_WIDTH) - 64'd1);
    @(posedge clk_i);
    event_i[ev_stall] <= 1'b1;
    @(posedge clk_i);
    event_i <= '0;
    expect_read(HPM_BASE_ADDR + 12'(ev_stall), '0);
    // minstret follows retire_i
    issue_cmd(CSR_MINSTRET, CSR_CMD_WRITE, '0);
    retired = 0;
    for (int k = 0; k < 16; k++) begin
        rnd = $random(seed);
        @(posedge clk_i);
        retire_i <= rnd[0];
        if (rnd[0]) retired++;
    end
    @(posedge clk_i);
    retire_i <= 1'b0;
    expect_read(CSR_MINSTRET, 64'(retired));
endtask

task automatic translation_enable();
    csr_word_u sp;
    csr_word_u st;
    sp           = '0;
    sp.satp.mode = 4'd8;                          // Sv39
    sp.satp.asid = 16'h005a;
    sp.satp.ppn  = 44'h9_1234_5678_a;
    raise_trap(64'd2, random_word(), '0);         // start from machine mode
    issue_cmd(CSR_SATP, CSR_CMD_WRITE, sp);
    expect_read(CSR_SATP, sp);
    compare("satp_ppn_o", satp_ppn_o, 44'h9_1234_5678_a);
    compare("en_translation_o in machine", en_translation_o, 1'b0);
    st             = '0;
    st.mstatus.mpp = PRIV_LVL_U;
    issue_cmd(CSR_MSTATUS, CSR_CMD_WRITE, st);
    trap_return();
    compare("en_translation_o in user", en_translation_o, 1'b1);
    raise_trap(64'd2, random_word(), '0);
    compare("en_translation_o back in machine", en_translation_o, 1'b0);
endtask

`endif

//--- test/tb_csr_top.sv
// Directed testbench for csr_top, the core side is driven straight from tasks.
// Inputs change on the rising edge, outputs are sampled on the falling edge.
// Expected values come from the CSR rules, each test sets up its own state.
`timescale 1ns/1ns

module tb_csr_top;
    import csr_pkg::*;
    import pmu_pkg::*;

    localparam int unsigned NUM_COUNTERS  = 4;
    localparam int unsigned COUNTER_WIDTH = 40;

    // ------------------------------
    // dut signals
    logic                     clk_i;
    logic                     rstn_i;
    logic [CSR_ADDR_SIZE-1:0] rw_addr_i;
    csr_cmd_t                 rw_cmd_i;
    logic [XLEN-1:0]          w_data_i;
    logic                     ex_i;
    logic [XLEN-1:0]          ex_cause_i;
    logic [XLEN-1:0]          ex_pc_i;
    logic [XLEN-1:0]          ex_tval_i;
    logic                     eret_i;
    logic                     retire_i;
    logic                     time_irq_i;
    logic                     irq_i;
    logic [NUM_COUNTERS-1:0]  event_i;
    logic [XLEN-1:0]          r_data_o;
    logic                     csr_xcpt_o;
    logic [XLEN-1:0]          csr_xcpt_cause_o;
    logic                     interrupt_o;
    logic [XLEN-1:0]          interrupt_cause_o;
    logic [XLEN-1:0]          evec_o;
    priv_lvl_t                priv_lvl_o;
    logic                     en_translation_o;
    logic [43:0]              satp_ppn_o;

    integer          seed;                        // $random state
    int              err_cnt;
    int              chk_cnt;
    logic            last_xcpt;                   // csr_xcpt_o seen by the last command
    logic [XLEN-1:0] last_cause;

    csr_top #(
        .NUM_COUNTERS  (NUM_COUNTERS),
        .COUNTER_WIDTH (COUNTER_WIDTH)
    ) i_dut (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .rw_addr_i         (rw_addr_i),
        .rw_cmd_i          (rw_cmd_i),
        .w_data_i          (w_data_i),
        .r_data_o          (r_data_o),
        .ex_i              (ex_i),
        .ex_cause_i        (ex_cause_i),
        .ex_pc_i           (ex_pc_i),
        .ex_tval_i         (ex_tval_i),
        .eret_i            (eret_i),
        .retire_i          (retire_i),
        .csr_xcpt_o        (csr_xcpt_o),
        .csr_xcpt_cause_o  (csr_xcpt_cause_o),
        .evec_o            (evec_o),
        .time_irq_i        (time_irq_i),
        .irq_i             (irq_i),
        .interrupt_o       (interrupt_o),
        .interrupt_cause_o (interrupt_cause_o),
        .priv_lvl_o        (priv_lvl_o),
        .en_translation_o  (en_translation_o),
        .satp_ppn_o        (satp_ppn_o),
        .event_i           (event_i)
    );

    `include "tb_csr_tasks.svh"

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;               // 100 ns period
    end

    // ------------------------------
    // test sequence
    initial begin
        seed       = 32'h9e27_6e21;
        err_cnt    = 0;
        chk_cnt    = 0;
        last_xcpt  = 1'b0;
        last_cause = '0;
        rstn_i     = 1'b0;
        rw_addr_i  = '0;
        rw_cmd_i   = CSR_CMD_NONE;
        w_data_i   = '0;
        ex_i       = 1'b0;
        ex_cause_i = '0;
        ex_pc_i    = '0;
        ex_tval_i  = '0;
        eret_i     = 1'b0;
        retire_i   = 1'b0;
        time_irq_i = 1'b0;
        irq_i      = 1'b0;
        event_i    = '0;
        repeat (8) @(posedge clk_i);               // reset held 8 cycles
        rstn_i <= 1'b1;
        @(negedge clk_i);
        compare("priv_lvl_o", priv_lvl_o, PRIV_LVL_M);
        compare("csr_xcpt_o", csr_xcpt_o, 1'b0);
        compare("interrupt_o", interrupt_o, 1'b0);
        compare("en_translation_o", en_translation_o, 1'b0);
        compare("evec_o", evec_o, '0);

        csr_command_rules();
        illegal_access();
        trap_entry_return();
        irq_masking();
        counter_events();
        translation_enable();

        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+test
logic/csr_pkg.sv
logic/pmu_pkg.sv
logic/hpm_counters.sv
logic/csr_file.sv
logic/csr_top.sv
test/tb_csr_top.sv

//--- Makefile
# Verilator build, run, lint and clean for the CSR subsystem testbench
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
LINT     = --lint-only --timing -Wall
TOP      = tb_csr_top
FLIST    = verilog.f
OBJ_DIR  = obj_dir
PASS_MSG = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

# the run fails unless the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(TOOL) $(LINT) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
